//--- design/keypad_pkg.sv
package keypad_pkg;

    // one key position on the 4x4 matrix, both nibbles active low
    typedef struct packed {
        logic [3:0] row;                                // low bit marks the pressed row
        logic [3:0] col;                                // low bit marks the driven column
    } key_coord_t;

    // single-cycle event from the scanner
    typedef struct packed {
        logic       valid;                              // one clock per debounced press
        key_coord_t coord;
    } key_event_t;

    // keypad layout
    //   row 0 : 1 2 3 A
    //   row 1 : 4 5 6 B
    //   row 2 : 7 8 9 C
    //   row 3 : * 0 # D
    localparam key_coord_t KEY_0         = 8'b0111_1101;
    localparam key_coord_t KEY_1         = 8'b1110_1110;
    localparam key_coord_t KEY_2         = 8'b1110_1101;
    localparam key_coord_t KEY_3         = 8'b1110_1011;
    localparam key_coord_t KEY_4         = 8'b1101_1110;
    localparam key_coord_t KEY_5         = 8'b1101_1101;
    localparam key_coord_t KEY_6         = 8'b1101_1011;
    localparam key_coord_t KEY_7         = 8'b1011_1110;
    localparam key_coord_t KEY_8         = 8'b1011_1101;
    localparam key_coord_t KEY_9         = 8'b1011_1011;

    localparam key_coord_t KEY_BACKSPACE = 8'b0111_1110; // "*" drops the last digit
    localparam key_coord_t KEY_ENTER     = 8'b0111_1011; // "#" completes the number
    localparam key_coord_t KEY_PAUSE     = 8'b1110_0111; // "A" pause or resume the cpu
    localparam key_coord_t KEY_TOGGLE    = 8'b1101_0111; // "B" keypad or switches
    localparam key_coord_t KEY_C         = 8'b1011_0111; // spare
    localparam key_coord_t KEY_D         = 8'b0111_0111; // spare

endpackage

//--- design/cpu_io_pkg.sv
package cpu_io_pkg;

    // where the next number for the cpu comes from
    typedef enum logic [1:0] {
        BLOCK  = 2'b00,                                 // waiting for the data memory to ask
        SWITCH = 2'b01,                                 // value taken from the toggle switches
        KEYPAD = 2'b10,                                 // digits typed on the keypad
        HALT   = 2'b11                                  // cpu held until resumed
    } input_mode_t;

    // flags handed to the hazard logic and the display
    typedef struct packed {
        logic input_complete;                           // number is ready in input_data
        logic switch_enable;                            // switches are the active source
        logic cpu_pause;                                // cpu must stall
    } input_status_t;

endpackage

//--- design/keypad_scanner.sv
`timescale 1ns/100ps

module keypad_scanner import keypad_pkg::*; #(
    parameter int SCAN_CYCLES    = 16,
    parameter int DEBOUNCE_SCANS = 3
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] rows,
    output logic [3:0] cols,
    output key_event_t key_event
);

    localparam int CYC_W   = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
    localparam int AGREE_W = $clog2(DEBOUNCE_SCANS + 1);

    logic [3:0]         rows_meta;
    logic [3:0]         rows_sync;
    logic [CYC_W-1:0]   cyc_cnt;
    logic               sample;
    logic               scan_end;
    logic [2:0]         row_hits;
    logic [2:0]         keys_sum;
    logic [1:0]         scan_keys;
    logic [1:0]         scan_keys_next;
    key_coord_t         scan_coord;
    key_coord_t         scan_coord_next;
    key_coord_t         candidate;
    logic [AGREE_W-1:0] agree_cnt;
    logic [AGREE_W-1:0] agree_next;
    logic               released;
    logic               emit;
    logic               event_valid;
    key_coord_t         event_coord;

    assign sample   = (cols != 4'hf) && (cyc_cnt == CYC_W'(SCAN_CYCLES - 1));
    assign scan_end = sample && (cols == 4'b0111);      // last column of the sweep

    always_comb begin
        row_hits = '0;
        for (int i = 0; i < 4; i++) begin
            row_hits = row_hits + {2'b00, ~rows_sync[i]};
        end
        keys_sum       = {1'b0, scan_keys} + row_hits;
        scan_keys_next = (keys_sum > 3'd2) ? 2'd2 : keys_sum[1:0]; // 2 means several keys
        scan_coord_next = (row_hits == 3'd1) ? '{row: rows_sync, col: cols} : scan_coord;

        if (agree_cnt != '0 && scan_coord_next == candidate) begin
            agree_next = (agree_cnt == AGREE_W'(DEBOUNCE_SCANS)) ? agree_cnt : agree_cnt + 1'b1;
        end else begin
            agree_next = AGREE_W'(1);                   // new candidate starts its count
        end

        emit = scan_end && (scan_keys_next == 2'd1) && released &&
               (agree_next == AGREE_W'(DEBOUNCE_SCANS));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rows_meta   <= 4'hf;
            rows_sync   <= 4'hf;
            cols        <= 4'hf;                        // idle, nothing driven
            cyc_cnt     <= '0;
            scan_keys   <= '0;
            agree_cnt   <= '0;
            released    <= 1'b1;
            event_valid <= 1'b0;
        end else begin
            rows_meta   <= rows;                        // rows come straight from the pins
            rows_sync   <= rows_meta;
            event_valid <= emit;

            if (cols == 4'hf) begin
                cols <= 4'b1110;                        // first sweep after reset
            end else if (sample) begin
                cols    <= {cols[2:0], cols[3]};
                cyc_cnt <= '0;
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end

            if (sample) begin
                scan_keys <= scan_end ? 2'd0 : scan_keys_next;
            end

            if (scan_end) begin
                agree_cnt <= (scan_keys_next == 2'd1) ? agree_next : '0;
                if (scan_keys_next == 2'd0) begin
                    released <= 1'b1;                   // clean scan rearms the next press
                end else if (emit) begin
                    released <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            scan_coord <= scan_coord_next;
        end
        if (scan_end && scan_keys_next == 2'd1) begin
            candidate <= scan_coord_next;
        end
        if (emit) begin
            event_coord <= scan_coord_next;
        end
    end

    assign key_event = '{valid: event_valid, coord: event_coord};

    // a held key must never repeat on back-to-back clocks
    assert property (@(posedge clk) disable iff (!rst_n)
        key_event.valid |=> !key_event.valid);

endmodule

//--- design/key_fifo.sv
`timescale 1ns/100ps

module key_fifo import keypad_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  key_event_t key_event,
    input  logic       pop,
    output logic       not_empty,
    output key_coord_t head
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    key_coord_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign do_pop    = pop && not_empty;
    assign do_push   = key_event.valid && (!full || do_pop); // full without pop drops the event
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= key_event.coord;
        end
    end

    // the input unit must only pop what it can see
    assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty);

    assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(FIFO_DEPTH));

endmodule

//--- design/input_unit.sv
`timescale 1ns/100ps

module input_unit import keypad_pkg::*, cpu_io_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int SWITCH_CNT = 16,
    parameter int MAX_DIGITS = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  not_empty,        // a key event waits at the fifo head
    input  key_coord_t            head,
    output logic                  pop,
    input  logic [SWITCH_CNT-1:0] switch_map,       // toggle switches, unsynced
    input  logic                  input_enable,     // data memory wants a number
    input  logic                  uart_complete,    // program upload finished
    output logic [DATA_WIDTH-1:0] input_data,
    output input_status_t         status
);

    localparam int CNT_W = $clog2(MAX_DIGITS + 1);

    input_mode_t           mode;
    logic [DATA_WIDTH-1:0] keypad_data;
    logic [CNT_W-1:0]      digit_cnt;
    logic [4:0]            digit_info;
    logic                  is_digit;
    logic [3:0]            digit;

    // returns {is_digit, value}
    function automatic logic [4:0] decode_digit(key_coord_t key);
        case (key)
            KEY_0:   return {1'b1, 4'd0};
            KEY_1:   return {1'b1, 4'd1};
            KEY_2:   return {1'b1, 4'd2};
            KEY_3:   return {1'b1, 4'd3};
            KEY_4:   return {1'b1, 4'd4};
            KEY_5:   return {1'b1, 4'd5};
            KEY_6:   return {1'b1, 4'd6};
            KEY_7:   return {1'b1, 4'd7};
            KEY_8:   return {1'b1, 4'd8};
            KEY_9:   return {1'b1, 4'd9};
            default: return 5'd0;
        endcase
    endfunction

    assign digit_info = decode_digit(head);
    assign is_digit   = digit_info[4];
    assign digit      = digit_info[3:0];
    assign pop        = not_empty;                  // every event is consumed, used or not

    assign input_data = status.switch_enable ? DATA_WIDTH'(switch_map) : keypad_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode        <= BLOCK;
            keypad_data <= '0;
            digit_cnt   <= '0;
            status      <= '0;
        end else begin
            case (mode)
                BLOCK: begin
                    if (not_empty && head == KEY_PAUSE) begin
                        mode             <= HALT;
                        status.cpu_pause <= 1'b1;
                    end else if (input_enable) begin
                        mode                  <= KEYPAD;
                        keypad_data           <= '0;
                        digit_cnt             <= '0;
                        status.input_complete <= 1'b0;
                    end
                end

                KEYPAD: begin
                    if (!input_enable) begin
                        mode <= BLOCK;                  // request withdrawn
                    end else if (not_empty) begin
                        if (is_digit) begin
                            if (digit_cnt < CNT_W'(MAX_DIGITS)) begin
                                keypad_data <= keypad_data * DATA_WIDTH'(10) + DATA_WIDTH'(digit);
                                digit_cnt   <= digit_cnt + 1'b1;
                            end
                        end else begin
                            case (head)
                                KEY_BACKSPACE: begin
                                    if (digit_cnt != '0) begin
                                        keypad_data <= keypad_data / DATA_WIDTH'(10);
                                        digit_cnt   <= digit_cnt - 1'b1;
                                    end
                                end
                                KEY_ENTER: begin
                                    mode                  <= BLOCK;
                                    status.input_complete <= 1'b1;
                                end
                                KEY_PAUSE: begin
                                    mode                  <= HALT;
                                    status.input_complete <= 1'b1;
                                    status.cpu_pause      <= 1'b1;
                                end
                                KEY_TOGGLE: begin
                                    mode                 <= SWITCH;
                                    status.switch_enable <= 1'b1;
                                end
                                default: ;                  // C and D do nothing here
                            endcase
                        end
                    end
                end

                SWITCH: begin
                    if (not_empty) begin
                        case (head)
                            KEY_TOGGLE: begin
                                mode                 <= KEYPAD;
                                status.switch_enable <= 1'b0;
                            end
                            KEY_ENTER: begin
                                mode                  <= BLOCK;
                                status.input_complete <= 1'b1;
                            end
                            KEY_PAUSE: begin
                                mode                  <= HALT;
                                status.input_complete <= 1'b1;
                                status.cpu_pause      <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end

                HALT: begin
                    // resume only once the upload is done
                    if (not_empty && head == KEY_PAUSE && uart_complete) begin
                        mode             <= BLOCK;
                        status.cpu_pause <= 1'b0;
                    end
                end

                default: mode <= BLOCK;
            endcase
        end
    end

    // pause flag tracks the HALT mode from the edge that enters it
    assert property (@(posedge clk) disable iff (!rst_n)
        status.cpu_pause == (mode == HALT));

    assert property (@(posedge clk) disable iff (!rst_n)
        digit_cnt <= CNT_W'(MAX_DIGITS));

endmodule

//--- design/keypad_input_top.sv
`timescale 1ns/100ps

module keypad_input_top import keypad_pkg::*, cpu_io_pkg::*; #(
    parameter int DATA_WIDTH     = 32,
    parameter int SWITCH_CNT     = 16,
    parameter int MAX_DIGITS     = 8,               // eight decimal digits fit in 32 bits
    parameter int FIFO_DEPTH     = 4,
    parameter int SCAN_CYCLES    = 16,
    parameter int DEBOUNCE_SCANS = 3
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [3:0]            rows,
    output logic [3:0]            cols,
    input  logic [SWITCH_CNT-1:0] switch_map,
    input  logic                  input_enable,
    input  logic                  uart_complete,
    output logic [DATA_WIDTH-1:0] input_data,
    output input_status_t         status
);

    key_event_t key_event;
    logic       pop;
    logic       not_empty;
    key_coord_t head;

    keypad_scanner #(
        .SCAN_CYCLES   (SCAN_CYCLES),
        .DEBOUNCE_SCANS(DEBOUNCE_SCANS)
    ) u_scanner (
        .clk      (clk),
        .rst_n    (rst_n),
        .rows     (rows),
        .cols     (cols),
        .key_event(key_event)
    );

    key_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_event(key_event),
        .pop      (pop),
        .not_empty(not_empty),
        .head     (head)
    );

    input_unit #(
        .DATA_WIDTH(DATA_WIDTH),
        .SWITCH_CNT(SWITCH_CNT),
        .MAX_DIGITS(MAX_DIGITS)
    ) u_input (
        .clk          (clk),
        .rst_n        (rst_n),
        .not_empty    (not_empty),
        .head         (head),
        .pop          (pop),
        .switch_map   (switch_map),
        .input_enable (input_enable),
        .uart_complete(uart_complete),
        .input_data   (input_data),
        .status       (status)
    );

endmodule

//--- tests/keypad_model.sv
`timescale 1ns/100ps

module keypad_model import keypad_pkg::*; (
    input  logic [3:0] cols,                            // active low, from the scanner
    input  key_coord_t pressed,                         // all ones while no key is down
    output logic [3:0] rows                             // pulled up unless a key closes
);

    logic col_driven;

    // the pressed key connects its row to its column
    assign col_driven = |(~pressed.col & ~cols);

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            rows[r] = !(col_driven && !pressed.row[r]);
        end
    end

endmodule

//--- tests/tb_keypad_input.sv
`timescale 1ns/100ps

module tb_keypad_input import keypad_pkg::*, cpu_io_pkg::*; ();

    localparam int DATA_WIDTH     = 32;
    localparam int SWITCH_CNT     = 16;
    localparam int MAX_DIGITS     = 8;
    localparam int SCAN_CYCLES    = 16;
    localparam int DEBOUNCE_SCANS = 3;
    localparam int CLK_PERIOD     = 100;
    localparam int SCAN_CLKS      = 4 * SCAN_CYCLES;   // one sweep over all columns
    localparam int PRESS_CLKS     = (DEBOUNCE_SCANS + 4) * SCAN_CLKS;
    localparam int NUM_PRESSES    = 47;
    localparam int WATCHDOG_NS    = (NUM_PRESSES + 4) * PRESS_CLKS * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    logic [3:0]            rows;
    logic [3:0]            cols;
    logic [SWITCH_CNT-1:0] switch_map;
    logic                  input_enable;
    logic                  uart_complete;
    logic [DATA_WIDTH-1:0] input_data;
    input_status_t         status;
    key_coord_t            pressed;
    logic                  check_now;
    input_mode_t           exp_mode;
    input_status_t         exp_status;
    logic [DATA_WIDTH-1:0] exp_data;
    logic [DATA_WIDTH-1:0] exp_out;
    logic [DATA_WIDTH-1:0] done_data;                   // value expected when complete rises
    logic                  done_switch;
    int                    exp_cnt;
    key_coord_t            digit_keys [10] = '{KEY_0, KEY_1, KEY_2, KEY_3, KEY_4,
                                               KEY_5, KEY_6, KEY_7, KEY_8, KEY_9};

    assign exp_out = exp_status.switch_enable ? DATA_WIDTH'(switch_map) : exp_data;

    keypad_input_top #(
        .DATA_WIDTH    (DATA_WIDTH),
        .SWITCH_CNT    (SWITCH_CNT),
        .MAX_DIGITS    (MAX_DIGITS),
        .SCAN_CYCLES   (SCAN_CYCLES),
        .DEBOUNCE_SCANS(DEBOUNCE_SCANS)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .rows         (rows),
        .cols         (cols),
        .switch_map   (switch_map),
        .input_enable (input_enable),
        .uart_complete(uart_complete),
        .input_data   (input_data),
        .status       (status)
    );

    keypad_model keypad (.cols(cols), .pressed(pressed), .rows(rows));

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "stopped at the first failed check");
    endtask

    assert property (@(posedge clk) disable iff (!rst_n) check_now |-> input_data == exp_out)
        else report_fail("input_data differs from the expected number");
    assert property (@(posedge clk) disable iff (!rst_n) check_now |-> status == exp_status)
        else report_fail("status flags differ from the expected flags");
    assert property (@(posedge clk) disable iff (!rst_n)
        check_now |-> uut.u_input.mode == exp_mode)
        else report_fail("input mode differs from the expected mode");
    assert property (@(posedge clk) disable iff (!rst_n) $rose(status.input_complete) |->
        input_data == done_data && status.switch_enable == done_switch)
        else report_fail("wrong value or source when input completed");

    // once the sweep runs exactly one column is pulled low
    assert property (@(posedge clk) disable iff (!rst_n) $past(rst_n) |-> $onehot(~cols))
        else report_fail("keypad columns are not driven one at a time");

    function automatic int digit_of(input key_coord_t key);
        for (int i = 0; i < 10; i++) begin
            if (digit_keys[i] == key) return i;
        end
        return -1;
    endfunction

    // ENTER, PAUSE and TOGGLE while a number is being entered
    task automatic leave_entry(input key_coord_t key);
        if (key == KEY_ENTER || key == KEY_PAUSE) begin
            done_data   = exp_status.switch_enable ? DATA_WIDTH'(switch_map) : exp_data;
            done_switch = exp_status.switch_enable;
            exp_status.input_complete = 1'b1;
            exp_status.cpu_pause = (key == KEY_PAUSE);
            exp_mode = (key == KEY_PAUSE) ? HALT : BLOCK;
        end else if (key == KEY_TOGGLE) begin
            exp_status.switch_enable = (exp_mode == KEYPAD);
            exp_mode = (exp_mode == KEYPAD) ? SWITCH : KEYPAD;
        end
    endtask

    task automatic follow_enable();
        if (exp_mode == BLOCK && input_enable) begin
            exp_mode = KEYPAD;                          // a fresh number starts
            exp_data = '0;
            exp_cnt  = 0;
            exp_status.input_complete = 1'b0;
        end else if (exp_mode == KEYPAD && !input_enable) begin
            exp_mode = BLOCK;
        end
    endtask

    task automatic apply_key(input key_coord_t key);
        int d;
        d = digit_of(key);
        if (exp_mode == BLOCK && key == KEY_PAUSE) begin
            exp_mode = HALT;
            exp_status.cpu_pause = 1'b1;
        end else if (exp_mode == HALT && key == KEY_PAUSE && uart_complete) begin
            exp_mode = BLOCK;
            exp_status.cpu_pause = 1'b0;
        end else if (exp_mode == KEYPAD && d >= 0) begin
            if (exp_cnt < MAX_DIGITS) begin
                exp_data = exp_data * 10 + DATA_WIDTH'(d);
                exp_cnt++;
            end
        end else if (exp_mode == KEYPAD && key == KEY_BACKSPACE) begin
            if (exp_cnt > 0) begin
                exp_data = exp_data / 10;
                exp_cnt--;
            end
        end else if (exp_mode == KEYPAD || exp_mode == SWITCH) begin
            leave_entry(key);
        end
        follow_enable();
    endtask

    task automatic check_outputs();
        check_now = 1'b1;
        @(negedge clk);
        check_now = 1'b0;
    endtask

    task automatic press_key(input key_coord_t key);
        apply_key(key);
        pressed = key;
        repeat ((DEBOUNCE_SCANS + 2) * SCAN_CLKS) @(negedge clk);
        pressed = '1;                                   // release for two sweeps
        repeat (2 * SCAN_CLKS) @(negedge clk);
        check_outputs();
    endtask

    task automatic type_digits(input int n);
        repeat (n) press_key(digit_keys[$urandom_range(9)]);
    endtask

    task automatic set_enable(input logic en);
        input_enable = en;
        follow_enable();
        @(negedge clk);                                 // mode moves on the next edge
        check_outputs();
    endtask

    task automatic set_switches();
        switch_map = SWITCH_CNT'($urandom);
        check_outputs();
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the key press sequence did not finish in time");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h1eb0868d));
        rst_n         = 1'b0;
        pressed       = '1;
        switch_map    = '0;
        input_enable  = 1'b0;
        uart_complete = 1'b0;
        check_now     = 1'b0;
        exp_mode      = BLOCK;
        exp_status    = '0;
        exp_data      = '0;
        exp_cnt       = 0;
        done_data     = '0;
        done_switch   = 1'b0;
        repeat (5) @(negedge clk);
        if (cols !== 4'hf) begin
            report_fail("keypad columns are not idle during reset");
        end
        rst_n = 1'b1;
        check_outputs();

        set_enable(1'b1);                               // plain entry
        type_digits(5);
        press_key(KEY_C);
        press_key(KEY_ENTER);
        type_digits(2);                                 // backspace past the first digit
        repeat (3) press_key(KEY_BACKSPACE);
        type_digits(3);
        press_key(KEY_BACKSPACE);
        press_key(KEY_ENTER);
        type_digits(10);                                // two digits over the limit
        press_key(KEY_ENTER);

        type_digits(2);                                 // switches as the source
        press_key(KEY_TOGGLE);
        repeat (3) set_switches();
        press_key(KEY_TOGGLE);
        press_key(KEY_TOGGLE);
        set_switches();
        press_key(KEY_ENTER);
        press_key(KEY_TOGGLE);
        press_key(KEY_TOGGLE);

        type_digits(1);                                 // pause, then resume after upload
        press_key(KEY_PAUSE);
        press_key(KEY_PAUSE);
        uart_complete = 1'b1;
        press_key(KEY_PAUSE);
        uart_complete = 1'b0;

        type_digits(2);                                 // request withdrawn mid entry
        set_enable(1'b0);
        type_digits(2);
        set_enable(1'b1);
        type_digits(2);
        press_key(KEY_ENTER);

        $display("** PASS **");
        $finish;
    end

endmodule

//--- keypad_input.f
design/keypad_pkg.sv
design/cpu_io_pkg.sv
design/keypad_scanner.sv
design/key_fifo.sv
design/input_unit.sv
design/keypad_input_top.sv
tests/keypad_model.sv
tests/tb_keypad_input.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_keypad_input -f keypad_input.f -o sim_keypad_input &&
./obj_dir/sim_keypad_input | tee /dev/stderr | grep -qF '** PASS **' &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
